// ==== logic/div_params.svh ====
/*
  Width and iteration-count macros for the divide unit.
  DIV_CNT_W must be wide enough to hold DIV_ITER_D.
*/
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand widths
`define DIV_XLEN   64
`define DIV_WLEN   32

// iteration counter
`define DIV_CNT_W  7
`define DIV_ITER_D 64  // doubleword ops, one quotient bit per clock
`define DIV_ITER_W 32  // word ops

`endif

// ==== logic/div_pkg.sv ====
/*
  Shared types for the divide unit.
  The op encoding mirrors funct3 plus a word flag; keep the bit meanings in sync
  with the decode in div_op_ctrl.
*/
`include "div_params.svh"

package div_pkg;

  // ======================================================================
  // operation encoding
  // bit 2 = word form, bit 1 = remainder, bit 0 = unsigned
  // ======================================================================
  typedef enum logic [2:0] {
    DIV_OP_DIV   = 3'b000,
    DIV_OP_DIVU  = 3'b001,
    DIV_OP_REM   = 3'b010,
    DIV_OP_REMU  = 3'b011,
    DIV_OP_DIVW  = 3'b100,
    DIV_OP_DIVUW = 3'b101,
    DIV_OP_REMW  = 3'b110,
    DIV_OP_REMUW = 3'b111
  } div_op_e;

  // ======================================================================
  // operand / result word
  // ======================================================================
  typedef struct packed {
    logic [`DIV_WLEN-1:0] hi;
    logic [`DIV_WLEN-1:0] lo;  // the only half that matters for *w ops
  } div_half_t;

  typedef union packed {
    logic [`DIV_XLEN-1:0] dword;
    div_half_t            half;
  } div_word_u;

endpackage

// ==== logic/div_op_ctrl.sv ====
/*
  Request acceptance, op decode and special-case detection.
  rst_n is synchronous and active HIGH. One operation is held until release_i;
  inputs are sampled only on the accepting edge.
*/
`include "div_params.svh"

module div_op_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid_i,
  input  div_pkg::div_op_e     op_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  input  logic                 release_i,
  output logic                 in_ready_o,
  output logic                 start_o,
  output logic                 bypass_o,
  output div_pkg::div_word_u   special_val_o,
  output logic [`DIV_XLEN-1:0] abs_dividend_o,
  output logic [`DIV_XLEN-1:0] abs_divisor_o,
  output logic                 word_o,
  output logic                 neg_quot_o,
  output logic                 neg_rem_o,
  output logic                 sel_rem_o
);
  import div_pkg::*;

  localparam logic [`DIV_WLEN-1:0] W_MIN = {1'b1, {(`DIV_WLEN-1){1'b0}}};
  localparam logic [`DIV_XLEN-1:0] X_MIN = {1'b1, {(`DIV_XLEN-1){1'b0}}};

  typedef enum logic [1:0] {ST_IDLE, ST_PREP, ST_BUSY} state_e;

  state_e    state_q;
  div_op_e   op_q;
  div_word_u dvd_q, dvs_q;      // raw operands as accepted
  div_word_u dvd_ext, dvs_ext;  // sign-extended at op width
  div_word_u dvd_mag, dvs_mag;
  div_word_u special_val;
  logic      is_word, is_rem, is_signed;
  logic      dvd_neg, dvs_neg;
  logic      div_zero, sgn_ovf, special;

  assign in_ready_o = (state_q == ST_IDLE);

  // ======================================================================
  // decode and special cases, evaluated during the prep cycle
  // ======================================================================
  always_comb begin
    is_word   = op_q[2];
    is_rem    = op_q[1];
    is_signed = ~op_q[0];

    // word ops look only at the lo half
    dvd_ext.dword = is_word ? {{`DIV_WLEN{dvd_q.half.lo[`DIV_WLEN-1]}}, dvd_q.half.lo}
                            : dvd_q.dword;
    dvs_ext.dword = is_word ? {{`DIV_WLEN{dvs_q.half.lo[`DIV_WLEN-1]}}, dvs_q.half.lo}
                            : dvs_q.dword;

    dvd_neg = is_signed & dvd_ext.dword[`DIV_XLEN-1];
    dvs_neg = is_signed & dvs_ext.dword[`DIV_XLEN-1];

    // extension preserves zero and all-ones, so one compare covers both widths
    div_zero = (dvs_ext.dword == '0);
    sgn_ovf  = is_signed & (&dvs_ext.dword) &
               (is_word ? (dvd_q.half.lo == W_MIN) : (dvd_q.dword == X_MIN));
    special  = div_zero | sgn_ovf;

    if (div_zero) begin
      special_val.dword = is_rem ? dvd_ext.dword : '1;
    end else begin
      special_val.dword = is_rem ? '0 : dvd_ext.dword;  // overflow
    end

    dvd_mag.dword = dvd_neg ? -dvd_ext.dword : dvd_ext.dword;
    dvs_mag.dword = dvs_neg ? -dvs_ext.dword : dvs_ext.dword;
  end

  // ======================================================================
  // control state
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q    <= ST_IDLE;
      start_o    <= 1'b0;
      bypass_o   <= 1'b0;
      word_o     <= 1'b0;
      neg_quot_o <= 1'b0;
      neg_rem_o  <= 1'b0;
      sel_rem_o  <= 1'b0;
    end else begin
      start_o  <= 1'b0;  // single-cycle pulses
      bypass_o <= 1'b0;
      case (state_q)
        ST_IDLE: if (in_valid_i) state_q <= ST_PREP;
        ST_PREP: begin
          state_q    <= ST_BUSY;
          start_o    <= ~special;
          bypass_o   <= special;
          word_o     <= is_word;
          neg_quot_o <= dvd_neg ^ dvs_neg;
          neg_rem_o  <= dvd_neg;  // remainder follows dividend sign
          sel_rem_o  <= is_rem;
        end
        ST_BUSY: if (release_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      op_q        <= op_i;
      dvd_q.dword <= dividend_i;
      dvs_q.dword <= divisor_i;
    end
    if (state_q == ST_PREP) begin
      special_val_o <= special_val;
      // word dividend sits in the upper half, the core eats it from the top
      abs_dividend_o <= is_word ? {dvd_mag.half.lo, {`DIV_WLEN{1'b0}}} : dvd_mag.dword;
      abs_divisor_o  <= is_word ? {{`DIV_WLEN{1'b0}}, dvs_mag.half.lo} : dvs_mag.dword;
    end
  end

endmodule

// ==== logic/div_iter_core.sv ====
/*
  Restoring divider, one quotient bit per clock on unsigned magnitudes.
  The first step is taken on the start edge, so done_o rises N cycles after
  start_i. start_i must not arrive while a division is running.
*/
`include "div_params.svh"

module div_iter_core (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  logic                 word_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  output logic                 done_o,
  output logic [`DIV_XLEN-1:0] quotient_o,
  output logic [`DIV_XLEN-1:0] remainder_o
);

  localparam int XL = `DIV_XLEN;

  logic [2*XL-1:0]       rq_q;     // {partial remainder, dividend/quotient}
  logic [XL-1:0]         dvs_q;
  logic [`DIV_CNT_W-1:0] cnt_q;    // steps still to go
  logic [`DIV_CNT_W-1:0] iter_n;
  logic [2*XL-1:0]       rq_src;
  logic [XL-1:0]         dvs_src;
  logic [XL:0]           trial;    // 65 bits, top bit is the borrow
  logic [2*XL-1:0]       rq_nxt;
  logic                  busy;

  assign iter_n = word_i ? `DIV_CNT_W'(`DIV_ITER_W) : `DIV_CNT_W'(`DIV_ITER_D);
  assign busy   = (cnt_q != '0);

  // ======================================================================
  // one restoring step
  // ======================================================================
  always_comb begin
    // on start, step straight from the fresh operands
    rq_src  = start_i ? {{XL{1'b0}}, dividend_i} : rq_q;
    dvs_src = start_i ? divisor_i : dvs_q;

    // shifted partial remainder can be XL+1 bits wide
    trial = rq_src[2*XL-1:XL-1] - {1'b0, dvs_src};

    if (trial[XL]) begin
      rq_nxt = {rq_src[2*XL-2:0], 1'b0};                   // restore
    end else begin
      rq_nxt = {trial[XL-1:0], rq_src[XL-2:0], 1'b1};      // keep difference
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        cnt_q <= iter_n - 1'b1;  // first step already taken
      end else if (busy) begin
        cnt_q  <= cnt_q - 1'b1;
        done_o <= (cnt_q == `DIV_CNT_W'(1));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i || busy) rq_q <= rq_nxt;
    if (start_i) dvs_q <= divisor_i;
  end

  // word ops leave the quotient in the low 32 bits after 32 shifts
  assign quotient_o  = rq_q[XL-1:0];
  assign remainder_o = rq_q[2*XL-1:XL];

endmodule

// ==== logic/div_result_fmt.sv ====
/*
  Sign fix-up, quotient/remainder select and output register.
  rst_n is synchronous and active HIGH. result_o holds until out_ready_i;
  release_o is combinational from out_valid_o and out_ready_i.
*/
`include "div_params.svh"

module div_result_fmt (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 done_i,
  input  logic                 bypass_i,
  input  div_pkg::div_word_u   special_val_i,
  input  logic [`DIV_XLEN-1:0] quotient_i,
  input  logic [`DIV_XLEN-1:0] remainder_i,
  input  logic                 neg_quot_i,
  input  logic                 neg_rem_i,
  input  logic                 sel_rem_i,
  input  logic                 word_i,
  input  logic                 out_ready_i,
  output logic                 out_valid_o,
  output logic [`DIV_XLEN-1:0] result_o,
  output logic                 release_o
);
  import div_pkg::*;

  div_word_u raw_val;
  div_word_u sgn_val;
  div_word_u fmt_val;
  logic      negate;

  // ======================================================================
  // formatting
  // ======================================================================
  always_comb begin
    raw_val.dword = sel_rem_i ? remainder_i : quotient_i;
    negate        = sel_rem_i ? neg_rem_i : neg_quot_i;

    sgn_val.dword = negate ? -raw_val.dword : raw_val.dword;  // two's complement

    // *w results: sign-extend bit 31 of the lo half
    if (word_i) begin
      fmt_val.dword = {{`DIV_WLEN{sgn_val.half.lo[`DIV_WLEN-1]}}, sgn_val.half.lo};
    end else begin
      fmt_val.dword = sgn_val.dword;
    end
  end

  // ======================================================================
  // output register
  // ======================================================================
  assign release_o = out_valid_o & out_ready_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      out_valid_o <= 1'b0;
    end else if (done_i || bypass_i) begin
      out_valid_o <= 1'b1;
    end else if (release_o) begin
      out_valid_o <= 1'b0;
    end
  end

  // bypass value already sign-extended upstream
  always_ff @(posedge clk) begin
    if (bypass_i) begin
      result_o <= special_val_i.dword;
    end else if (done_i) begin
      result_o <= fmt_val.dword;
    end
  end

endmodule

// ==== logic/div_unit_top.sv ====
/*
  Iterative RV64M divide unit, one operation in flight.
  Latency from acceptance: 66 cycles doubleword, 34 word, 2 for div-by-zero
  or signed overflow. rst_n is synchronous and active HIGH.
*/
`include "div_params.svh"

module div_unit_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  div_pkg::div_op_e     op_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [`DIV_XLEN-1:0] result_o
);
  import div_pkg::*;

  logic                 start, bypass, done, release_w;
  logic                 word, neg_quot, neg_rem, sel_rem;
  logic [`DIV_XLEN-1:0] abs_dividend, abs_divisor;
  logic [`DIV_XLEN-1:0] quotient, remainder;
  div_word_u            special_val;

  div_op_ctrl ctrl_i (
    .clk(clk), .rst_n(rst_n),
    .in_valid_i(in_valid_i), .op_i(op_i),
    .dividend_i(dividend_i), .divisor_i(divisor_i),
    .release_i(release_w), .in_ready_o(in_ready_o),
    .start_o(start), .bypass_o(bypass), .special_val_o(special_val),
    .abs_dividend_o(abs_dividend), .abs_divisor_o(abs_divisor),
    .word_o(word), .neg_quot_o(neg_quot), .neg_rem_o(neg_rem), .sel_rem_o(sel_rem)
  );

  div_iter_core core_i (
    .clk(clk), .rst_n(rst_n),
    .start_i(start), .word_i(word),
    .dividend_i(abs_dividend), .divisor_i(abs_divisor),
    .done_o(done), .quotient_o(quotient), .remainder_o(remainder)
  );

  div_result_fmt fmt_i (
    .clk(clk), .rst_n(rst_n),
    .done_i(done), .bypass_i(bypass), .special_val_i(special_val),
    .quotient_i(quotient), .remainder_i(remainder),
    .neg_quot_i(neg_quot), .neg_rem_i(neg_rem), .sel_rem_i(sel_rem), .word_i(word),
    .out_ready_i(out_ready_i), .out_valid_o(out_valid_o),
    .result_o(result_o), .release_o(release_w)
  );

endmodule

// ==== verification/div_tb_clkgen.sv ====
/*
  Clock and reset for the divide unit testbench.
  10 ns clock; rst_n is active high and is held for 5 cycles.
*/
module div_tb_clkgen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b0;  // released away from the active edge
  end

endmodule

// ==== verification/div_tb.sv ====
/*
  Testbench for the RV64M divide unit. Directed divide-by-zero and overflow
  cases come first, then random ops with random back-pressure on out_ready_i.
  Inputs change on the falling edge, outputs are sampled there too.
*/
`include "div_params.svh"

module div_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import div_pkg::*;

  localparam int NUM_OPS        = 600;
  localparam int NUM_DIRECTED   = 16;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 75;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid_i;
  logic                 in_ready_o;
  div_op_e              op_i;
  logic [`DIV_XLEN-1:0] dividend_i;
  logic [`DIV_XLEN-1:0] divisor_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic [`DIV_XLEN-1:0] result_o;

  integer               seed;
  int                   cycle = 0;
  logic                 pending;     // an op is between acceptance and consumption
  logic [`DIV_XLEN-1:0] exp_q[$];
  int                   lat_q[$];
  int                   acc_q[$];
  logic [1:0]           hold_q[$];

  div_tb_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

  div_unit_top dut_i (
    .clk(clk), .rst_n(rst_n),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .op_i(op_i),
    .dividend_i(dividend_i), .divisor_i(divisor_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .result_o(result_o)
  );

  // ======================================================================
  // failure reporting
  // ======================================================================
  task automatic flag_mismatch(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    $display("[ERROR] %s expected %h actual %h", name, expected, actual);
    $display("Result: FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // ======================================================================
  // reference model from the RV64M rules
  // ======================================================================
  function automatic logic [63:0] ref_result(input div_op_e op, input logic [63:0] a,
                                             input logic [63:0] b);
    logic [63:0] q;
    logic [63:0] r;
    logic [31:0] q32;
    logic [31:0] r32;
    if (op[2]) begin
      if (b[31:0] == 32'h0) begin
        q32 = '1;
        r32 = a[31:0];
      end else if (!op[0] && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) begin
        q32 = a[31:0];
        r32 = '0;
      end else if (op[0]) begin
        q32 = a[31:0] / b[31:0];
        r32 = a[31:0] % b[31:0];
      end else begin
        q32 = $signed(a[31:0]) / $signed(b[31:0]);
        r32 = $signed(a[31:0]) % $signed(b[31:0]);
      end
      q = {{32{q32[31]}}, q32};  // word results are always sign-extended
      r = {{32{r32[31]}}, r32};
    end else begin
      if (b == 64'h0) begin
        q = '1;
        r = a;
      end else if (!op[0] && a == 64'h8000_0000_0000_0000 && b == '1) begin
        q = a;
        r = '0;
      end else if (op[0]) begin
        q = a / b;
        r = a % b;
      end else begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
      end
    end
    return op[1] ? r : q;
  endfunction

  function automatic int expected_latency(input div_op_e op, input logic [63:0] a,
                                          input logic [63:0] b);
    logic special;
    if (op[2]) begin
      special = (b[31:0] == 32'h0) ||
                (!op[0] && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff);
    end else begin
      special = (b == 64'h0) || (!op[0] && a == 64'h8000_0000_0000_0000 && b == '1);
    end
    if (special) return 2;
    return op[2] ? 34 : 66;
  endfunction

  // ======================================================================
  // stimulus
  // ======================================================================
  function automatic logic [63:0] pick_operand();
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    r  = $random(seed);
    hi = $random(seed);
    lo = $random(seed);
    case (r[3:0])
      4'd0:    return 64'h0;
      4'd1:    return '1;
      4'd2:    return 64'h8000_0000_0000_0000;
      4'd3:    return {hi, 32'h8000_0000};          // word min with junk above
      4'd4:    return 64'hffff_ffff_8000_0000;
      4'd5:    return 64'h1;
      4'd6:    return {hi, 32'hffff_ffff};
      4'd7:    return {{48{lo[15]}}, lo[15:0]};     // small signed
      default: return {hi, lo};
    endcase
  endfunction

  // sel[3] clear gives divide by zero for op sel[2:0]
  // sel[3] set gives signed overflow with sel[1] word, sel[0] rem, sel[2] junk high bits
  task automatic pick_directed(input int idx, output div_op_e op,
                               output logic [63:0] a, output logic [63:0] b);
    logic [3:0]  sel;
    logic [31:0] hi;
    logic [31:0] lo;
    sel = idx[3:0];
    hi  = $random(seed);
    lo  = $random(seed);
    if (!sel[3]) begin
      op = div_op_e'(sel[2:0]);
      a  = pick_operand();
      b  = sel[2] ? {hi, 32'h0} : 64'h0;
    end else begin
      op = div_op_e'({sel[1], sel[0], 1'b0});
      if (sel[1]) begin
        a = {sel[2] ? hi : 32'hffff_ffff, 32'h8000_0000};
        b = {sel[2] ? lo : 32'hffff_ffff, 32'hffff_ffff};
      end else begin
        a = 64'h8000_0000_0000_0000;
        b = '1;
      end
    end
  endtask

  initial begin : stimulus
    div_op_e     op;
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] r;
    seed       = 32'hc565ac8e;
    in_valid_i = 1'b0;
    op_i       = DIV_OP_DIV;
    dividend_i = '0;
    divisor_i  = '0;
    do @(negedge clk); while (rst_n);
    assert (in_ready_o && !out_valid_o)
      else abort_run("after reset in_ready_o should be high and out_valid_o low");
    for (int i = 0; i < NUM_OPS; i++) begin
      while (!in_ready_o) @(negedge clk);
      if (i < NUM_DIRECTED) begin
        pick_directed(i, op, a, b);
      end else begin
        r  = $random(seed);
        op = div_op_e'(r[2:0]);
        a  = pick_operand();
        b  = pick_operand();
      end
      r = $random(seed);
      exp_q.push_back(ref_result(op, a, b));
      lat_q.push_back(expected_latency(op, a, b));
      hold_q.push_back(r[1:0]);  // cycles to withhold out_ready_i
      in_valid_i = 1'b1;
      op_i       = op;
      dividend_i = a;
      divisor_i  = b;
      @(negedge clk);
      in_valid_i = 1'b0;
      assert (!in_ready_o) else abort_run("request was not accepted while in_ready_o was high");
      acc_q.push_back(cycle);  // index of the accepting edge
    end
  end

  // ======================================================================
  // monitors and compare
  // ======================================================================
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) abort_run("timeout, the run did not finish in time");
  end

  always @(posedge clk) begin
    if (rst_n) pending <= 1'b0;
    else if (in_valid_i && in_ready_o) pending <= 1'b1;
    else if (out_valid_o && out_ready_i) pending <= 1'b0;
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      if (pending) begin
        assert (!in_ready_o) else abort_run("in_ready_o went high with an op in flight");
      end else begin
        assert (!out_valid_o) else abort_run("out_valid_o high with no op in flight");
      end
    end
  end

  initial begin : compare
    logic [63:0] expected;
    logic [63:0] held;
    int          latency;
    int          exp_lat;
    logic [1:0]  hold;
    out_ready_i = 1'b0;
    for (int n = 0; n < NUM_OPS; n++) begin
      do @(negedge clk); while (rst_n || !out_valid_o);
      expected = exp_q.pop_front();
      exp_lat  = lat_q.pop_front();
      hold     = hold_q.pop_front();
      latency  = cycle - acc_q.pop_front();
      assert (latency == exp_lat)
        else flag_mismatch("out_valid_o latency", 64'(exp_lat), 64'(latency));
      assert (result_o === expected) else flag_mismatch("result_o", expected, result_o);
      held = result_o;
      repeat (hold) begin
        @(negedge clk);
        assert (out_valid_o) else abort_run("out_valid_o dropped while out_ready_i was low");
        assert (result_o === held) else flag_mismatch("result_o", held, result_o);
      end
      out_ready_i = 1'b1;
      @(negedge clk);
      out_ready_i = 1'b0;
      assert (!out_valid_o && in_ready_o)
        else abort_run("unit did not return to idle after the result was consumed");
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+logic
logic/div_pkg.sv
logic/div_op_ctrl.sv
logic/div_iter_core.sv
logic/div_result_fmt.sv
logic/div_unit_top.sv
verification/div_tb_clkgen.sv
verification/div_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV64M divide unit

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
